// File: source/cnn_numeric_pkg.sv
// Pixel and weight formats with the fixed-point kernel constants
package cnn_numeric_pkg;

    // Grayscale pixel format
    localparam int PIXEL_BITS = 8;
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // Unsigned weight in Q6
    localparam int WEIGHT_BITS = 8;
    typedef logic [WEIGHT_BITS-1:0] weight_t;

    localparam int WEIGHT_Q_SHIFT = 6;

    // 64/9 truncated, shared by all nine taps of the averaging kernel
    localparam weight_t KERNEL_WEIGHT = weight_t'(7);

    // Width of one pixel times weight product
    localparam int PRODUCT_BITS = PIXEL_BITS + WEIGHT_BITS;

endpackage

// File: source/cnn_geometry_pkg.sv
// Kernel and pooling geometry with the derived counter widths
package cnn_geometry_pkg;

    // Convolution window edge
    localparam int KERNEL_SIZE = 3;

    // Pooling block edge
    localparam int POOL_SIZE = 2;

    // Counts rows held in the line buffer, saturating at KERNEL_SIZE
    localparam int ROW_COUNT_BITS = $clog2(KERNEL_SIZE + 1);

    // Counts convolved rows folded into one pooled row
    localparam int POOL_COUNT_BITS = $clog2(POOL_SIZE + 1);

endpackage

// File: source/pixel_deserializer.sv
// Pixel deserializer that packs one image row and flags the last row
module pixel_deserializer #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic                    clock_i,
    input  logic                    reset_i,
    input  cnn_numeric_pkg::pixel_t in_pixel_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    output cnn_numeric_pkg::pixel_t row_o [IMAGE_WIDTH],
    output logic                    row_valid_o,
    output logic                    row_last_o,
    input  logic                    row_accept_i
);
    import cnn_numeric_pkg::*;

    localparam int COUNT_BITS = $clog2(IMAGE_WIDTH);
    localparam logic [COUNT_BITS-1:0] LAST_INDEX = COUNT_BITS'(IMAGE_WIDTH - 1);

    pixel_t                row_q [IMAGE_WIDTH];
    logic [COUNT_BITS-1:0] col_q;
    logic [COUNT_BITS-1:0] row_idx_q;
    logic                  full_q;
    logic                  last_q;
    logic                  take_pixel;

    assign in_ready_o  = !full_q;
    assign take_pixel  = in_valid_i && in_ready_o;
    assign row_o       = row_q;
    assign row_valid_o = full_q;
    assign row_last_o  = last_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            col_q     <= '0;
            row_idx_q <= '0;
            full_q    <= 1'b0;
            last_q    <= 1'b0;
        end else if (take_pixel) begin
            if (col_q == LAST_INDEX) begin
                // Row complete, present it and advance the image row count
                col_q     <= '0;
                full_q    <= 1'b1;
                last_q    <= (row_idx_q == LAST_INDEX);
                row_idx_q <= (row_idx_q == LAST_INDEX) ? '0 : row_idx_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end else if (full_q && row_accept_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clock_i) begin
        if (take_pixel) begin
            row_q[col_q] <= in_pixel_i;
        end
    end

    // The source holds its pixel while the row register is closed
    a_source_hold: assert property (@(posedge clock_i) disable iff (reset_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_pixel_i));

endmodule

// File: source/conv_line_buffer.sv
// Three-row line buffer with a wrapped 3x3 window multiplexer
module conv_line_buffer #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic                             clock_i,
    input  cnn_numeric_pkg::pixel_t          row_i [IMAGE_WIDTH],
    input  logic                             shift_row_i,
    input  logic [$clog2(IMAGE_WIDTH)-1:0]   column_i,
    output cnn_numeric_pkg::pixel_t          window_o [cnn_geometry_pkg::KERNEL_SIZE]
                                                      [cnn_geometry_pkg::KERNEL_SIZE]
);
    import cnn_numeric_pkg::*;
    import cnn_geometry_pkg::*;

    // Entry 0 holds the newest row
    pixel_t rows_q [KERNEL_SIZE][IMAGE_WIDTH];

    always_ff @(posedge clock_i) begin
        if (shift_row_i) begin
            for (int r = KERNEL_SIZE - 1; r > 0; r--) begin
                rows_q[r] <= rows_q[r-1];
            end
            rows_q[0] <= row_i;
        end
    end

    // Columns c, c+1 and c+2, wrapping past the right edge
    always_comb begin
        int idx;
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            for (int k = 0; k < KERNEL_SIZE; k++) begin
                idx = int'(column_i) + k;
                if (idx >= IMAGE_WIDTH) begin
                    idx = idx - IMAGE_WIDTH;
                end
                window_o[r][k] = rows_q[r][idx];
            end
        end
    end

endmodule

// File: source/conv_kernel_mac.sv
// Registered multiply-accumulate of one 3x3 window with the averaging kernel
module conv_kernel_mac (
    input  logic                    clock_i,
    input  cnn_numeric_pkg::pixel_t window_i [cnn_geometry_pkg::KERNEL_SIZE]
                                             [cnn_geometry_pkg::KERNEL_SIZE],
    output cnn_numeric_pkg::pixel_t result_o
);
    import cnn_numeric_pkg::*;
    import cnn_geometry_pkg::*;

    logic [PRODUCT_BITS-1:0] sum_d;

    always_comb begin
        sum_d = '0;
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            for (int k = 0; k < KERNEL_SIZE; k++) begin
                // Each product is scaled back before it is summed
                sum_d = sum_d + ((PRODUCT_BITS'(window_i[r][k]) * KERNEL_WEIGHT)
                                 >> WEIGHT_Q_SHIFT);
            end
        end
    end

    always_ff @(posedge clock_i) begin
        result_o <= sum_d[PIXEL_BITS-1:0];
    end

    // Truncation to a pixel is safe only while the sum stays in range
    a_sum_bound: assert property (@(posedge clock_i)
        sum_d[PRODUCT_BITS-1:PIXEL_BITS] == '0);

endmodule

// File: source/conv_row_engine.sv
// Row engine FSM that fills the line buffer and computes one convolved row
module conv_row_engine #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic                    clock_i,
    input  logic                    reset_i,
    input  cnn_numeric_pkg::pixel_t row_i [IMAGE_WIDTH],
    input  logic                    row_valid_i,
    input  logic                    row_last_i,
    output logic                    row_accept_o,
    output cnn_numeric_pkg::pixel_t conv_row_o [IMAGE_WIDTH],
    output logic                    conv_valid_o,
    output logic                    conv_last_o,
    input  logic                    conv_accept_i
);
    import cnn_numeric_pkg::*;
    import cnn_geometry_pkg::*;

    localparam int COL_BITS = $clog2(IMAGE_WIDTH);

    typedef enum logic [1:0] {
        S_FETCH,
        S_MAC_WAIT,
        S_CAPTURE,
        S_HOLD
    } state_t;

    state_t                    state_q;
    logic [COL_BITS-1:0]       col_q;
    logic [ROW_COUNT_BITS-1:0] row_count_q;
    logic [ROW_COUNT_BITS-1:0] next_row_count;
    logic                      last_q;
    logic                      shift_row;
    pixel_t                    window [KERNEL_SIZE][KERNEL_SIZE];
    pixel_t                    mac_result;
    pixel_t                    out_row_q [IMAGE_WIDTH];

    conv_line_buffer #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) line_buffer_i (
        .clock_i     (clock_i),
        .row_i       (row_i),
        .shift_row_i (shift_row),
        .column_i    (col_q),
        .window_o    (window)
    );

    conv_kernel_mac mac_i (
        .clock_i  (clock_i),
        .window_i (window),
        .result_o (mac_result)
    );

    assign row_accept_o = (state_q == S_FETCH);
    assign shift_row    = row_accept_o && row_valid_i;
    assign conv_valid_o = (state_q == S_HOLD);
    assign conv_last_o  = last_q;
    assign conv_row_o   = out_row_q;

    // Saturates once the window is filled
    assign next_row_count = (row_count_q == ROW_COUNT_BITS'(KERNEL_SIZE))
                          ? row_count_q : row_count_q + 1'b1;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q     <= S_FETCH;
            col_q       <= '0;
            row_count_q <= '0;
            last_q      <= 1'b0;
        end else begin
            case (state_q)
                S_FETCH: begin
                    if (row_valid_i) begin
                        last_q      <= row_last_i;
                        col_q       <= '0;
                        // A last row empties the buffer for the next image
                        row_count_q <= row_last_i ? '0 : next_row_count;
                        if (next_row_count == ROW_COUNT_BITS'(KERNEL_SIZE)) begin
                            state_q <= S_MAC_WAIT;
                        end
                    end
                end
                S_MAC_WAIT: begin
                    state_q <= S_CAPTURE;
                end
                S_CAPTURE: begin
                    if (col_q == COL_BITS'(IMAGE_WIDTH - 1)) begin
                        state_q <= S_HOLD;
                    end else begin
                        col_q   <= col_q + 1'b1;
                        state_q <= S_MAC_WAIT;
                    end
                end
                S_HOLD: begin
                    if (conv_accept_i) begin
                        state_q <= S_FETCH;
                    end
                end
                default: state_q <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (state_q == S_CAPTURE) begin
            out_row_q[col_q] <= mac_result;
        end
    end

    a_col_range: assert property (@(posedge clock_i) disable iff (reset_i)
        col_q < IMAGE_WIDTH);

endmodule

// File: source/max_pool_row.sv
// Max pooling over 2x2 blocks, one convolved row at a time
module max_pool_row #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic                    clock_i,
    input  logic                    reset_i,
    input  cnn_numeric_pkg::pixel_t conv_row_i [IMAGE_WIDTH],
    input  logic                    conv_valid_i,
    input  logic                    conv_last_i,
    output logic                    conv_accept_o,
    output cnn_numeric_pkg::pixel_t pool_row_o [IMAGE_WIDTH / cnn_geometry_pkg::POOL_SIZE],
    output logic                    pool_valid_o,
    input  logic                    pool_accept_i
);
    import cnn_numeric_pkg::*;
    import cnn_geometry_pkg::*;

    localparam int OUT_WIDTH = IMAGE_WIDTH / POOL_SIZE;
    localparam int POS_BITS  = $clog2(OUT_WIDTH);

    typedef enum logic [1:0] {
        S_GET_ROW,
        S_CALC,
        S_HOLD
    } state_t;

    state_t                     state_q;
    logic [POS_BITS-1:0]        pos_q;
    logic [POOL_COUNT_BITS-1:0] row_count_q;
    logic                       last_q;
    pixel_t                     in_row_q [IMAGE_WIDTH];
    pixel_t                     pool_q [OUT_WIDTH];
    pixel_t                     best;

    assign conv_accept_o = (state_q == S_GET_ROW);
    assign pool_valid_o  = (state_q == S_HOLD);
    assign pool_row_o    = pool_q;

    // Running maximum of one output position against its input pair
    always_comb begin
        best = pool_q[pos_q];
        for (int k = 0; k < POOL_SIZE; k++) begin
            if (in_row_q[pos_q * POOL_SIZE + k] > best) begin
                best = in_row_q[pos_q * POOL_SIZE + k];
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q     <= S_GET_ROW;
            pos_q       <= '0;
            row_count_q <= '0;
            last_q      <= 1'b0;
            pool_q      <= '{default: '0};
        end else begin
            case (state_q)
                S_GET_ROW: begin
                    if (conv_valid_i) begin
                        last_q  <= conv_last_i;
                        pos_q   <= '0;
                        state_q <= S_CALC;
                    end
                end
                S_CALC: begin
                    pool_q[pos_q] <= best;
                    pos_q         <= pos_q + 1'b1;
                    if (pos_q == POS_BITS'(OUT_WIDTH - 1)) begin
                        row_count_q <= row_count_q + 1'b1;
                        if (row_count_q == POOL_COUNT_BITS'(POOL_SIZE - 1) || last_q) begin
                            state_q <= S_HOLD;
                        end else begin
                            state_q <= S_GET_ROW;
                        end
                    end
                end
                S_HOLD: begin
                    if (pool_accept_i) begin
                        // Start the next block from a clean accumulator
                        pool_q      <= '{default: '0};
                        row_count_q <= '0;
                        state_q     <= S_GET_ROW;
                    end
                end
                default: state_q <= S_GET_ROW;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (conv_accept_o && conv_valid_i) begin
            in_row_q <= conv_row_i;
        end
    end

endmodule

// File: source/pixel_serializer.sv
// Row-to-pixel serializer for the pooled rows
module pixel_serializer #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic                    clock_i,
    input  logic                    reset_i,
    input  cnn_numeric_pkg::pixel_t pool_row_i [IMAGE_WIDTH / 2],
    input  logic                    pool_valid_i,
    output logic                    pool_accept_o,
    output cnn_numeric_pkg::pixel_t out_pixel_o,
    output logic                    out_valid_o,
    input  logic                    out_ready_i
);
    localparam int OUT_WIDTH = IMAGE_WIDTH / 2;
    localparam int IDX_BITS  = $clog2(OUT_WIDTH);

    logic [IDX_BITS-1:0] idx_q;
    logic                done_q;

    // Pixels are read straight from the held pool row
    assign out_valid_o   = pool_valid_i && !done_q;
    assign out_pixel_o   = pool_row_i[idx_q];
    assign pool_accept_o = done_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            idx_q  <= '0;
            done_q <= 1'b0;
        end else if (done_q) begin
            done_q <= 1'b0;
        end else if (out_valid_o && out_ready_i) begin
            if (idx_q == IDX_BITS'(OUT_WIDTH - 1)) begin
                idx_q  <= '0;
                done_q <= 1'b1;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // A stalled pixel holds, which relies on the pool stage keeping its row
    a_hold_stall: assert property (@(posedge clock_i) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> $stable(out_pixel_o));

endmodule

// File: source/cnn_pipeline_top.sv
// Pipeline top with deserializer, convolution engine, max pool and serializer
module cnn_pipeline_top #(
    parameter int IMAGE_WIDTH = 28
) (
    input  logic                    clock_i,
    input  logic                    reset_i,
    input  cnn_numeric_pkg::pixel_t in_pixel_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    output cnn_numeric_pkg::pixel_t out_pixel_o,
    output logic                    out_valid_o,
    input  logic                    out_ready_i
);
    import cnn_numeric_pkg::*;
    import cnn_geometry_pkg::*;

    // Packed input rows
    pixel_t row [IMAGE_WIDTH];
    logic   row_valid;
    logic   row_last;
    logic   row_accept;

    // Convolved rows
    pixel_t conv_row [IMAGE_WIDTH];
    logic   conv_valid;
    logic   conv_last;
    logic   conv_accept;

    // Pooled rows
    pixel_t pool_row [IMAGE_WIDTH / POOL_SIZE];
    logic   pool_valid;
    logic   pool_accept;

    pixel_deserializer #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) deserializer_i (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .in_pixel_i   (in_pixel_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .row_o        (row),
        .row_valid_o  (row_valid),
        .row_last_o   (row_last),
        .row_accept_i (row_accept)
    );

    conv_row_engine #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) engine_i (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .row_i         (row),
        .row_valid_i   (row_valid),
        .row_last_i    (row_last),
        .row_accept_o  (row_accept),
        .conv_row_o    (conv_row),
        .conv_valid_o  (conv_valid),
        .conv_last_o   (conv_last),
        .conv_accept_i (conv_accept)
    );

    max_pool_row #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) pool_i (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .conv_row_i    (conv_row),
        .conv_valid_i  (conv_valid),
        .conv_last_i   (conv_last),
        .conv_accept_o (conv_accept),
        .pool_row_o    (pool_row),
        .pool_valid_o  (pool_valid),
        .pool_accept_i (pool_accept)
    );

    pixel_serializer #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) serializer_i (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .pool_row_i    (pool_row),
        .pool_valid_i  (pool_valid),
        .pool_accept_o (pool_accept),
        .out_pixel_o   (out_pixel_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i)
    );

endmodule

// File: include/cnn_tb_model.svh
// Reference model of the pooled pixel stream and the test image generator

typedef enum int {
    IMG_GRADIENT,
    IMG_CONSTANT,
    IMG_RANDOM
} image_kind_t;

// Convolved pixel of the three rows from top, columns wrapping at the right edge
function automatic int conv_reference(input int top, input int col);
    int sum;
    sum = 0;
    for (int r = 0; r < KERNEL_SIZE; r++) begin
        for (int k = 0; k < KERNEL_SIZE; k++) begin
            // Each tap is scaled back by the Q6 shift before the sum
            sum += (int'(image_q[top + r][(col + k) % IMAGE_WIDTH]) * int'(KERNEL_WEIGHT))
                   >> WEIGHT_Q_SHIFT;
        end
    end
    return sum;
endfunction

// Appends the whole expected output stream for the image in image_q
function automatic void pipeline_reference();
    int best;
    int value;
    for (int p = 0; p < CONV_ROWS; p += POOL_SIZE) begin
        for (int j = 0; j < IMAGE_WIDTH / POOL_SIZE; j++) begin
            best = 0;
            // A trailing odd convolved row is pooled on its own
            for (int dr = 0; dr < POOL_SIZE && p + dr < CONV_ROWS; dr++) begin
                for (int dc = 0; dc < POOL_SIZE; dc++) begin
                    value = conv_reference(p + dr, j * POOL_SIZE + dc);
                    if (value > best) begin
                        best = value;
                    end
                end
            end
            expected_q.push_back(pixel_t'(best));
        end
    end
endfunction

// Fills image_q with a horizontal gradient, a constant level or random pixels
function automatic void make_image(input image_kind_t kind, input pixel_t level);
    for (int r = 0; r < IMAGE_WIDTH; r++) begin
        for (int c = 0; c < IMAGE_WIDTH; c++) begin
            case (kind)
                IMG_GRADIENT: image_q[r][c] = pixel_t'((c * 255) / (IMAGE_WIDTH - 1));
                IMG_CONSTANT: image_q[r][c] = level;
                default:      image_q[r][c] = pixel_t'($random(seed));
            endcase
        end
    end
endfunction

// File: bench/cnn_tb.sv
// Testbench for the pooling pipeline with stimulus, compare process and error report
module cnn_tb;
    import cnn_numeric_pkg::*;
    import cnn_geometry_pkg::*;

    localparam int IMAGE_WIDTH  = 28;
    localparam int CONV_ROWS    = IMAGE_WIDTH - KERNEL_SIZE + 1;
    localparam int POOLED_COUNT = ((CONV_ROWS + POOL_SIZE - 1) / POOL_SIZE)
                                * (IMAGE_WIDTH / POOL_SIZE);
    localparam int ACCEPT_LIMIT = 2000;
    localparam int DRAIN_LIMIT  = 10000;
    // Longer than one row through engine, pool and serializer
    localparam int QUIET_CYCLES = 4 * IMAGE_WIDTH;

    logic   clock_i;
    logic   reset_i;
    pixel_t in_pixel_i;
    logic   in_valid_i;
    logic   in_ready_o;
    pixel_t out_pixel_o;
    logic   out_valid_o;
    logic   out_ready_i;

    pixel_t image_q [IMAGE_WIDTH][IMAGE_WIDTH];
    pixel_t expected_q [$];
    integer seed = 32'h53a4;
    integer ready_seed = 32'h53a4;
    logic   random_ready = 1'b0;
    logic   aborted = 1'b0;
    int     out_count = 0;
    int     mismatch_count = 0;
    int     timeout_count = 0;
    int     extra_count = 0;

    `include "cnn_tb_model.svh"

    cnn_pipeline_top #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) dut_i (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .in_pixel_i  (in_pixel_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_pixel_o (out_pixel_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    initial begin
        clock_i = 1'b0;
        forever #50 clock_i = ~clock_i;
    end

    // Sink readiness, stalling at random while a test asks for it
    initial begin
        out_ready_i = 1'b1;
        forever begin
            @(posedge clock_i);
            out_ready_i <= random_ready ? (($random(ready_seed) & 3) != 0) : 1'b1;
        end
    end

    task automatic check_pixel(input string name, input pixel_t actual, input pixel_t expected);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s expected %0d got %0d",
                     $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s expected %b got %b", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("mismatch at time %0t: %s expected %0d got %0d",
                     $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    // Compare process, one expected value per output transfer
    always @(posedge clock_i) begin
        if (!reset_i && out_valid_o && out_ready_i) begin
            if (expected_q.size() == 0) begin
                $display("Unexpected output pixel %0d at time %0t with nothing left to expect",
                         out_pixel_o, $time);
                extra_count++;
            end else begin
                check_pixel($sformatf("out_pixel_o[%0d]", out_count), out_pixel_o,
                            expected_q.pop_front());
            end
            out_count++;
        end
    end

    task automatic wait_input_accept();
        int cycles;
        cycles = 0;
        @(posedge clock_i);
        while (!in_ready_o && cycles < ACCEPT_LIMIT) begin
            @(posedge clock_i);
            cycles++;
        end
        if (!in_ready_o) begin
            $display("Timeout at time %0t: in_ready_o stayed low for %0d cycles", $time, cycles);
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic send_image(input bit with_gaps);
        int gap;
        for (int r = 0; r < IMAGE_WIDTH; r++) begin
            for (int c = 0; c < IMAGE_WIDTH && !aborted; c++) begin
                gap = with_gaps ? ($unsigned($random(seed)) % 4) : 0;
                if (gap != 0) begin
                    in_valid_i <= 1'b0;
                    repeat (gap) @(posedge clock_i);
                end
                in_pixel_i <= image_q[r][c];
                in_valid_i <= 1'b1;
                wait_input_accept();
            end
        end
        in_valid_i <= 1'b0;
    endtask

    task automatic wait_output_drain();
        int cycles;
        cycles = 0;
        while (!aborted && expected_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clock_i);
            cycles++;
        end
        if (!aborted && expected_q.size() != 0) begin
            $display("Timeout at time %0t: %0d expected pixels never came out",
                     $time, expected_q.size());
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    // Stray outputs after the drain are caught by the compare process
    task automatic watch_for_stray_outputs();
        int cycles;
        cycles = 0;
        while (!aborted && cycles < QUIET_CYCLES) begin
            @(posedge clock_i);
            cycles++;
        end
    endtask

    task automatic run_image(input string name, input image_kind_t kind, input pixel_t level,
                             input bit with_gaps);
        int start;
        start = out_count;
        make_image(kind, level);
        pipeline_reference();
        send_image(with_gaps);
        wait_output_drain();
        watch_for_stray_outputs();
        check_count(name, out_count - start, POOLED_COUNT);
    endtask

    initial begin
        int start;
        reset_i    = 1'b1;
        in_pixel_i = '0;
        in_valid_i = 1'b0;
        repeat (16) @(posedge clock_i);
        reset_i <= 1'b0;
        @(posedge clock_i);
        check_flag("out_valid_o", out_valid_o, 1'b0);
        check_flag("in_ready_o", in_ready_o, 1'b1);

        run_image("gradient image outputs", IMG_GRADIENT, '0, 1'b0);
        run_image("full scale image outputs", IMG_CONSTANT, 8'd255, 1'b0);

        // Random image with input gaps against a stalling sink
        random_ready <= 1'b1;
        run_image("random image outputs", IMG_RANDOM, '0, 1'b1);
        random_ready <= 1'b0;

        // Second image follows the first without waiting for its results
        start = out_count;
        make_image(IMG_RANDOM, '0);
        pipeline_reference();
        send_image(1'b0);
        make_image(IMG_RANDOM, '0);
        pipeline_reference();
        send_image(1'b0);
        wait_output_drain();
        watch_for_stray_outputs();
        check_count("back to back image outputs", out_count - start, 2 * POOLED_COUNT);

        $display("Error counts: %0d mismatches, %0d timeouts, %0d unexpected outputs",
                 mismatch_count, timeout_count, extra_count);
        if (mismatch_count + timeout_count + extra_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
source/cnn_numeric_pkg.sv
source/cnn_geometry_pkg.sv
source/pixel_deserializer.sv
source/conv_line_buffer.sv
source/conv_kernel_mac.sv
source/conv_row_engine.sv
source/max_pool_row.sv
source/pixel_serializer.sv
source/cnn_pipeline_top.sv
bench/cnn_tb.sv

// File: Makefile
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module cnn_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vcnn_tb > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
